/* hw/csi_rx_pkg.sv */
// built for two lanes only so the 32-bit header always spans exactly two words
`default_nettype none

package csi_rx_pkg;

   //--------------------------------------------------
   // link geometry
   //--------------------------------------------------
   localparam int NUM_LANE   = 2;
   localparam int MAX_SKEW   = 2;              // worst lane lag in byte clocks
   localparam int FIFO_DEPTH = MAX_SKEW + 1;   // early lane runs up to MAX_SKEW ahead
   localparam int PTR_W      = $clog2(FIFO_DEPTH);
   localparam int SKEW_W     = $clog2(MAX_SKEW + 1);

   localparam logic [7:0] SYNC_BYTE   = 8'hB8; // hs leader byte
   localparam logic [5:0] LONG_DT_MIN = 6'h10; // from here up a payload follows

   // packet handler states
   localparam logic [1:0] ST_HUNT    = 2'd0;   // waiting for first header word
   localparam logic [1:0] ST_HEADER  = 2'd1;   // second header word next
   localparam logic [1:0] ST_PAYLOAD = 2'd2;
   localparam logic [1:0] ST_CRC     = 2'd3;   // crc word is swallowed

   //--------------------------------------------------
   // data types
   //--------------------------------------------------
   typedef logic [NUM_LANE-1:0][7:0] lane_data_t; // lane 0 in the low byte
   typedef logic [NUM_LANE-1:0]      lane_vld_t;

   // csi-2 data type field without the vc bits
   typedef enum logic [5:0] {
      DT_FS   = 6'h00,
      DT_FE   = 6'h01,
      DT_LS   = 6'h02,
      DT_LE   = 6'h03,
      DT_RAW8 = 6'h2A
   } csi_dt_t;

   // header bytes in wire order from bit 0 up
   typedef union packed {
      struct packed {
         logic [7:0]  ecc;
         logic [15:0] word_cnt;    // payload bytes
         logic [7:0]  data_id;
      } long_hdr;
      struct packed {
         logic [7:0]  ecc;
         logic [15:0] number;      // frame or line number
         logic [7:0]  data_id;
      } short_hdr;
   } csi_hdr_u;

endpackage : csi_rx_pkg

`default_nettype wire

/* hw/csi_byte_if.sv */
// plain strobes only and the producer cannot be stalled
`timescale 1ns/1ps
`default_nettype none

interface csi_byte_if
   import csi_rx_pkg::*;
();
   lane_data_t byte_data;      // aligned byte per lane
   lane_vld_t  byte_vld;       // lanes may rise on different cycles
   logic       wait_for_sync;  // level while the link hunts
   logic       packet_done;    // one-cycle pulse that unlocks all lanes

   // byte aligner side
   modport producer (
      output byte_data,
      output byte_vld,
      input  wait_for_sync,
      input  packet_done
   );

   // word aligner side
   modport buffer (
      input  byte_data,
      input  byte_vld,
      output wait_for_sync,
      output packet_done
   );

endinterface : csi_byte_if

`default_nettype wire

/* hw/csi_word_if.sv */
// one strobe for all lanes and no handshake back to the buffer
`timescale 1ns/1ps
`default_nettype none

interface csi_word_if
   import csi_rx_pkg::*;
();
   lane_data_t word_data;      // deskewed word
   logic       word_vld;       // all lanes in step
   logic       wait_for_sync;  // high between packets
   logic       packet_done;    // one-cycle pulse after the last word

   // word aligner side
   modport buffer (
      output word_data,
      output word_vld,
      input  wait_for_sync,
      input  packet_done
   );

   // packet handler side
   modport consumer (
      input  word_data,
      input  word_vld,
      output wait_for_sync,
      output packet_done
   );

endinterface : csi_word_if

`default_nettype wire

/* hw/csi_rx_align_byte.sv */
// bits are taken lsb first so offset k means the byte starts k bits into the previous byte
`timescale 1ns/1ps
`default_nettype none

module csi_rx_align_byte
   import csi_rx_pkg::*;
(
   input  logic         byte_clock,
   input  logic         rst_n,
   input  logic         enable,      // low acts as reset
   input  lane_data_t   deser_in,    // raw deserializer bytes
   csi_byte_if.producer bus
);

   //--------------------------------------------------
   // one aligner per lane
   //--------------------------------------------------
   for (genvar i = 0; i < NUM_LANE; i++) begin : g_lane
      logic [7:0]  prev;      // last cycle's raw byte
      logic [15:0] window;    // prev in the low half
      logic        locked;
      logic [2:0]  offset;    // bit offset found at sync
      logic        hit;
      logic [2:0]  hit_off;
      logic [7:0]  data_q;
      logic        vld_q;

      assign window = {deser_in[i], prev};

      // sync search over all eight offsets
      always_comb begin
         hit     = 1'b0;
         hit_off = 3'd0;
         for (int k = 7; k >= 0; k--) begin   // walks down so the lowest offset wins
            if (window[k +: 8] == SYNC_BYTE) begin
               hit     = 1'b1;
               hit_off = 3'(k);
            end
         end
      end

      // raw history and aligned byte
      always_ff @(posedge byte_clock) begin
         prev   <= deser_in[i];
         data_q <= window[offset +: 8];   // barrel shift by locked offset
      end

      // lock state
      always_ff @(posedge byte_clock) begin
         if (!rst_n || !enable) begin
            locked <= 1'b0;
            offset <= 3'd0;
            vld_q  <= 1'b0;
         end else if (bus.packet_done) begin
            locked <= 1'b0;            // back to search
            vld_q  <= 1'b0;            // drops the cycle after the pulse
         end else if (locked) begin
            vld_q  <= 1'b1;            // first byte is the one after sync
         end else if (bus.wait_for_sync && hit) begin
            locked <= 1'b1;
            offset <= hit_off;
         end
      end

      assign bus.byte_data[i] = data_q;
      assign bus.byte_vld[i]  = vld_q;
   end : g_lane

endmodule : csi_rx_align_byte

`default_nettype wire

/* hw/csi_rx_align_word.sv */
// lanes must stay valid once started since the read side never waits for a late byte
`timescale 1ns/1ps
`default_nettype none

module csi_rx_align_word
   import csi_rx_pkg::*;
(
   input  logic       byte_clock,
   input  logic       rst_n,
   input  logic       enable,
   csi_byte_if.buffer byte_side,
   csi_word_if.buffer word_side
);

   logic [7:0]        mem [NUM_LANE][FIFO_DEPTH];  // per-lane skew fifo
   logic [PTR_W-1:0]  wr_ptr [NUM_LANE];
   logic [PTR_W-1:0]  rd_ptr;                      // shared by all lanes
   lane_vld_t         seen;                        // lane has started
   logic              running;
   logic [SKEW_W-1:0] skew_cnt;
   logic              timeout;                     // late lane gave up
   logic              flush;
   logic              all_in;

   function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
      return (p == PTR_W'(FIFO_DEPTH - 1)) ? '0 : PTR_W'(p + 1'b1);
   endfunction

   assign flush  = word_side.packet_done | timeout;
   assign all_in = &(seen | byte_side.byte_vld);   // last lane arrives now or earlier

   //--------------------------------------------------
   // storage
   //--------------------------------------------------
   always_ff @(posedge byte_clock) begin
      for (int i = 0; i < NUM_LANE; i++) begin
         if (byte_side.byte_vld[i]) begin
            mem[i][wr_ptr[i]] <= byte_side.byte_data[i];
         end
      end
   end

   //--------------------------------------------------
   // pointers and skew timer
   //--------------------------------------------------
   always_ff @(posedge byte_clock) begin
      if (!rst_n || !enable || flush) begin
         for (int i = 0; i < NUM_LANE; i++) begin
            wr_ptr[i] <= '0;
         end
         rd_ptr   <= '0;
         seen     <= '0;
         running  <= 1'b0;
         skew_cnt <= '0;
         timeout  <= 1'b0;          // so the timeout is a single pulse
      end else begin
         for (int i = 0; i < NUM_LANE; i++) begin
            if (byte_side.byte_vld[i]) begin
               wr_ptr[i] <= ptr_inc(wr_ptr[i]);
               seen[i]   <= 1'b1;
            end
         end
         if (running) begin
            rd_ptr <= ptr_inc(rd_ptr);
         end else if (all_in) begin
            running <= 1'b1;        // word_vld one cycle after last lane
         end else if (|seen) begin
            if (skew_cnt == SKEW_W'(MAX_SKEW - 1)) begin
               timeout <= 1'b1;     // drop this packet
            end else begin
               skew_cnt <= SKEW_W'(skew_cnt + 1'b1);
            end
         end
      end
   end

   // read all lanes in step
   always_comb begin
      for (int i = 0; i < NUM_LANE; i++) begin
         word_side.word_data[i] = mem[i][rd_ptr];
      end
   end

   assign word_side.word_vld      = running;
   assign byte_side.wait_for_sync = word_side.wait_for_sync;   // relayed
   assign byte_side.packet_done   = flush;                     // handler pulse or timeout

endmodule : csi_rx_align_word

`default_nettype wire

/* hw/csi_rx_packet_handler.sv */
// no ecc correction and no crc check so a corrupt header is taken as it arrives
`timescale 1ns/1ps
`default_nettype none

module csi_rx_packet_handler
   import csi_rx_pkg::*;
(
   input  logic          byte_clock,
   input  logic          rst_n,
   input  logic          enable,
   csi_word_if.consumer  bus,
   output lane_data_t    payload,
   output logic          payload_vld,
   output logic          in_frame,
   output logic          in_line,
   output logic [15:0]   frame_number
);

   logic [1:0]  state;
   lane_data_t  hdr_lo;       // first header word
   csi_hdr_u    hdr;
   csi_dt_t     dt;
   logic        is_long;
   logic [15:0] pay_words;    // payload length in words
   logic [15:0] words_left;
   logic        line_open;    // between line start and line end
   logic        long_pay;     // inside a long packet
   logic        done_q;
   logic        wait_q;

   //--------------------------------------------------
   // header decode
   //--------------------------------------------------
   assign hdr       = {bus.word_data, hdr_lo};  // second word carries wc msb and ecc
   assign dt        = csi_dt_t'(hdr.short_hdr.data_id[5:0]);  // vc bits dropped
   assign is_long   = (dt >= LONG_DT_MIN);
   assign pay_words = 16'(hdr.long_hdr.word_cnt / NUM_LANE);

   // payload registers
   always_ff @(posedge byte_clock) begin
      payload <= bus.word_data;
      if (state == ST_HUNT) begin
         hdr_lo <= bus.word_data;
      end
   end

   //--------------------------------------------------
   // packet fsm
   //--------------------------------------------------
   always_ff @(posedge byte_clock) begin
      if (!rst_n || !enable) begin
         state        <= ST_HUNT;
         words_left   <= '0;
         payload_vld  <= 1'b0;
         in_frame     <= 1'b0;
         line_open    <= 1'b0;
         long_pay     <= 1'b0;
         frame_number <= '0;
         done_q       <= 1'b0;
         wait_q       <= 1'b1;          // hunting after reset
      end else begin
         done_q      <= 1'b0;
         payload_vld <= 1'b0;
         case (state)
            ST_HUNT: begin
               // ignore the stale word still flowing during our own done pulse
               if (bus.word_vld && !done_q) begin
                  wait_q <= 1'b0;
                  state  <= ST_HEADER;
               end
            end
            ST_HEADER: begin
               if (bus.word_vld) begin
                  if (is_long) begin
                     words_left <= pay_words;
                     long_pay   <= 1'b1;
                     state      <= (pay_words == '0) ? ST_CRC : ST_PAYLOAD;
                  end else begin
                     case (dt)
                        DT_FS: begin
                           in_frame     <= 1'b1;
                           frame_number <= hdr.short_hdr.number;
                        end
                        DT_FE:   in_frame  <= 1'b0;
                        DT_LS:   line_open <= 1'b1;
                        DT_LE:   line_open <= 1'b0;
                        default: ;               // other short packets pass
                     endcase
                     done_q <= 1'b1;             // short packet ends here
                     wait_q <= 1'b1;
                     state  <= ST_HUNT;
                  end
               end
            end
            ST_PAYLOAD: begin
               if (bus.word_vld) begin
                  payload_vld <= 1'b1;
                  words_left  <= words_left - 16'd1;
                  if (words_left == 16'd1) begin
                     state <= ST_CRC;
                  end
               end
            end
            default: begin                      // ST_CRC
               if (bus.word_vld) begin
                  long_pay <= 1'b0;
                  done_q   <= 1'b1;
                  wait_q   <= 1'b1;
                  state    <= ST_HUNT;
               end
            end
         endcase
      end
   end

   assign in_line           = line_open | long_pay;
   assign bus.packet_done   = done_q;
   assign bus.wait_for_sync = wait_q;

endmodule : csi_rx_packet_handler

`default_nettype wire

/* hw/csi_rx_top.sv */
// expects deserialized bytes already in the byte clock domain and has no phy or clock detect
`timescale 1ns/1ps
`default_nettype none

module csi_rx_top
   import csi_rx_pkg::*;
(
   input  logic        byte_clock,
   input  logic        rst_n,
   input  logic        enable,          // camera enable, low resets the link
   input  lane_data_t  deser_data,      // one byte per lane per cycle

   output lane_data_t  unpack_dat,      // long-packet payload
   output logic        unpack_dat_vld,
   output logic        in_line,
   output logic        in_frame,
   output logic [15:0] frame_number     // from the last frame start
);

   csi_byte_if byte_bus ();
   csi_word_if word_bus ();

   //--------------------------------------------------
   // byte and word alignment
   //--------------------------------------------------
   csi_rx_align_byte u_align_byte (
      .byte_clock (byte_clock),
      .rst_n      (rst_n),
      .enable     (enable),
      .deser_in   (deser_data),
      .bus        (byte_bus.producer)
   );

   csi_rx_align_word u_align_word (
      .byte_clock (byte_clock),
      .rst_n      (rst_n),
      .enable     (enable),
      .byte_side  (byte_bus.buffer),
      .word_side  (word_bus.buffer)
   );

   //--------------------------------------------------
   // depacketizer
   //--------------------------------------------------
   csi_rx_packet_handler u_depacket (
      .byte_clock   (byte_clock),
      .rst_n        (rst_n),
      .enable       (enable),
      .bus          (word_bus.consumer),
      .payload      (unpack_dat),
      .payload_vld  (unpack_dat_vld),
      .in_frame     (in_frame),
      .in_line      (in_line),
      .frame_number (frame_number)
   );

endmodule : csi_rx_top

`default_nettype wire

/* testbench/tb_csi_rx_model.svh */
// included inside the testbench module, two lanes only, streams must fit in STREAM_MAX cycles
`ifndef TB_CSI_RX_MODEL_SVH
`define TB_CSI_RX_MODEL_SVH

localparam int STREAM_MAX = 4096;
localparam int GAP        = 8;              // idle zero bytes between packets

logic [31:0] lcg_state = 32'd550;
logic [7:0]  raw_stream [NUM_LANE][STREAM_MAX];  // per-lane deserializer bytes
int          stream_len;
csi_dt_t     pkt_dt     [$];
logic [15:0] pkt_num    [$];                // frame number or word count
bit          pkt_keep   [$];                // 0 for the frame cut by enable
int          pkt_pay_at [$];                // first payload byte in pay_bytes
int          pkt_base   [$];                // first stream cycle of the packet
logic [7:0]  pay_bytes  [$];

function automatic logic [31:0] lcg_next();
   lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
   return lcg_state;
endfunction

// long packets get their random payload right away
function automatic void add_packet(input csi_dt_t dt, input logic [15:0] num, input bit keep);
   pkt_dt.push_back(dt);
   pkt_num.push_back(num);
   pkt_keep.push_back(keep);
   pkt_pay_at.push_back(pay_bytes.size());
   if (dt >= LONG_DT_MIN) begin
      for (int n = 0; n < int'(num); n++) begin
         pay_bytes.push_back(8'(lcg_next() >> 16));
      end
   end
endfunction

// --------------------------------------------------
// packet list to per-lane bit streams
// --------------------------------------------------
function automatic void build_stream();
   logic [7:0] bytes [$];     // wire order after the sync
   logic [7:0] b;
   int         base;
   int         lane_len;
   int         off;
   int         skew;
   int         pos;
   base = 4;
   for (int i = 0; i < NUM_LANE; i++) begin
      for (int c = 0; c < STREAM_MAX; c++) begin
         raw_stream[i][c] = 8'h00;   // idle between packets
      end
   end
   for (int p = 0; p < pkt_dt.size(); p++) begin
      bytes.delete();
      bytes.push_back({2'b00, pkt_dt[p]});   // vc 0
      bytes.push_back(pkt_num[p][7:0]);
      bytes.push_back(pkt_num[p][15:8]);
      bytes.push_back(8'h00);                // ecc not checked
      if (pkt_dt[p] >= LONG_DT_MIN) begin
         for (int n = 0; n < int'(pkt_num[p]); n++) begin
            bytes.push_back(pay_bytes[pkt_pay_at[p] + n]);
         end
         bytes.push_back(8'h00);             // crc lo
         bytes.push_back(8'h00);             // crc hi
      end
      lane_len = 1 + bytes.size() / NUM_LANE;
      pkt_base.push_back(base);
      for (int i = 0; i < NUM_LANE; i++) begin
         if (p < 8) begin                    // sweep offsets 0..7 and skews 0..2
            off  = (i == 0) ? p : 7 - p;
            skew = (i == 0) ? p % 3 : p / 3;
         end else begin
            off  = int'((lcg_next() >> 16) % 8);
            skew = int'((lcg_next() >> 16) % (MAX_SKEW + 1));
         end
         pos = (base + skew) * 8 + off;
         for (int n = 0; n < lane_len; n++) begin
            b = (n == 0) ? SYNC_BYTE : bytes[(n - 1) * NUM_LANE + i];  // round robin
            for (int k = 0; k < 8; k++) begin
               raw_stream[i][(pos + k) / 8][(pos + k) % 8] = b[k];   // lsb first
            end
            pos = pos + 8;
         end
      end
      base = base + lane_len + MAX_SKEW + 1 + GAP;   // +1 for the offset spill
   end
   stream_len = base + 24;   // tail for the idle check
endfunction

// --------------------------------------------------
// reference model
// --------------------------------------------------
function automatic void predict();
   lane_data_t w;
   exp_frame    = 16'd0;
   exp_in_frame = 1'b0;
   for (int p = 0; p < pkt_dt.size(); p++) begin
      if (pkt_keep[p]) begin
         case (pkt_dt[p])
            DT_FS: begin
               exp_in_frame = 1'b1;
               exp_frame    = pkt_num[p];
            end
            DT_FE:   exp_in_frame = 1'b0;
            default: ;
         endcase
         if (pkt_dt[p] >= LONG_DT_MIN) begin
            for (int n = 0; n < int'(pkt_num[p]); n += NUM_LANE) begin
               for (int i = 0; i < NUM_LANE; i++) begin
                  w[i] = pay_bytes[pkt_pay_at[p] + n + i];   // lane 0 takes the even byte
               end
               exp_word.push_back(w);
               exp_fnum.push_back(exp_frame);
            end
         end
      end
   end
endfunction

`endif

/* testbench/tb_csi_rx_top.sv */
// payload is checked for order and content only since the receiver latency varies per packet
`timescale 1ns/1ps
`default_nettype none

module tb_csi_rx_top
   import csi_rx_pkg::*;
();

   logic        byte_clock;
   logic        rst_n;
   logic        enable;
   lane_data_t  deser_data;
   lane_data_t  unpack_dat;
   logic        unpack_dat_vld;
   logic        in_line;
   logic        in_frame;
   logic [15:0] frame_number;

   lane_data_t  exp_word [$];     // expected payload in order
   logic [15:0] exp_fnum [$];     // frame number in effect per word
   logic [15:0] exp_frame;        // after the last kept packet
   logic        exp_in_frame;
   int          idle_cnt = 0;     // negedges since the last payload word
   logic        en_prev  = 1'b1;
   int          drop_start;
   int          drop_end;

   `include "tb_csi_rx_model.svh"

   csi_rx_top u_dut (
      .byte_clock     (byte_clock),
      .rst_n          (rst_n),
      .enable         (enable),
      .deser_data     (deser_data),
      .unpack_dat     (unpack_dat),
      .unpack_dat_vld (unpack_dat_vld),
      .in_line        (in_line),
      .in_frame       (in_frame),
      .frame_number   (frame_number)
   );

   initial byte_clock = 1'b0;
   always #10 byte_clock = ~byte_clock;   // 20 ns byte clock

   // --------------------------------------------------
   // compare tasks
   // --------------------------------------------------
   task automatic stop_on_error(input string msg);
      $display("** Error at %0t ns: %s", $time, msg);
      $display("CHECKS FAILED");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic check_word(input lane_data_t got, input lane_data_t exp, input string what);
      if (got !== exp) begin
         stop_on_error($sformatf("%s got %h expected %h", what, got, exp));
      end
   endtask

   task automatic check_number(input logic [15:0] got, input logic [15:0] exp,
                               input string what);
      if (got !== exp) begin
         stop_on_error($sformatf("%s got %0d expected %0d", what, got, exp));
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         stop_on_error($sformatf("%s got %b expected %b", what, got, exp));
      end
   endtask

   // outputs settle after posedge so negedge sampling is race free
   always @(negedge byte_clock) begin : compare
      lane_data_t  w;
      logic [15:0] n;
      if (rst_n && unpack_dat_vld) begin
         idle_cnt = 0;
         if (exp_word.size() == 0) begin
            stop_on_error("payload word arrived with none expected");
         end else begin
            w = exp_word.pop_front();
            n = exp_fnum.pop_front();
            check_word(unpack_dat, w, "payload word");
            check_number(frame_number, n, "frame_number during payload");
            check_flag(in_frame, 1'b1, "in_frame during payload");
            check_flag(in_line, 1'b1, "in_line during payload");
         end
      end else begin
         idle_cnt = idle_cnt + 1;
      end
      if (rst_n && !enable && !en_prev) begin   // disabled for a full edge
         check_flag(unpack_dat_vld, 1'b0, "payload valid while disabled");
         check_flag(in_frame, 1'b0, "in_frame while disabled");
         check_flag(in_line, 1'b0, "in_line while disabled");
      end
      en_prev = enable;
   end

   // --------------------------------------------------
   // stimulus
   // --------------------------------------------------
   initial begin
      rst_n      = 1'b0;
      enable     = 1'b1;
      deser_data = '0;
      // frame a, two lines
      add_packet(DT_FS, 16'(lcg_next() >> 8), 1'b1);
      add_packet(DT_LS, 16'd1, 1'b1);
      add_packet(DT_RAW8, 16'(NUM_LANE * (2 + (lcg_next() >> 16) % 30)), 1'b1);
      add_packet(DT_LE, 16'd1, 1'b1);
      add_packet(DT_LS, 16'd2, 1'b1);
      add_packet(DT_RAW8, 16'(NUM_LANE * (2 + (lcg_next() >> 16) % 30)), 1'b1);
      add_packet(DT_LE, 16'd2, 1'b1);
      add_packet(DT_FE, 16'd0, 1'b1);
      // frame b, enable drops in its long packet header
      add_packet(DT_FS, 16'(lcg_next() >> 8), 1'b0);
      add_packet(DT_LS, 16'd1, 1'b0);
      add_packet(DT_RAW8, 16'(NUM_LANE * (2 + (lcg_next() >> 16) % 30)), 1'b0);
      add_packet(DT_LE, 16'd1, 1'b0);
      add_packet(DT_FE, 16'd0, 1'b0);
      // frame c after recovery
      add_packet(DT_FS, 16'(lcg_next() >> 8), 1'b1);
      add_packet(DT_LS, 16'd1, 1'b1);
      add_packet(DT_RAW8, 16'(NUM_LANE * (2 + (lcg_next() >> 16) % 30)), 1'b1);
      add_packet(DT_LE, 16'd1, 1'b1);
      add_packet(DT_FE, 16'd0, 1'b1);
      build_stream();
      predict();
      drop_start = pkt_base[10] + 4;   // header in flight, no payload yet
      drop_end   = pkt_base[13] - 4;   // back on in the idle gap before frame c

      repeat (5) @(posedge byte_clock);
      #1 rst_n = 1'b1;
      for (int c = 0; c < stream_len; c++) begin
         @(posedge byte_clock);
         #1;
         for (int i = 0; i < NUM_LANE; i++) begin
            deser_data[i] = raw_stream[i][c];
         end
         enable = !(c >= drop_start && c < drop_end);
      end

      wait (idle_cnt >= 20);   // quiet after the last frame end
      check_flag(in_frame, exp_in_frame, "in_frame after frame end");
      check_flag(in_line, 1'b0, "in_line after frame end");
      check_number(frame_number, exp_frame, "frame_number after frame end");
      if (exp_word.size() != 0) begin
         $display("stream ended with %0d payload words never received", exp_word.size());
         $display("CHECKS FAILED");
         $fatal(1, "missing payload words");
      end else begin
         $display("ALL CHECKS PASSED");
         $finish;
      end
   end

   // watchdog at 4x the stream plus 100 cycles
   initial begin
      wait (stream_len > 0);
      #((4 * stream_len + 100) * 20);
      $display("watchdog expired, the stream did not complete");
      $display("CHECKS FAILED");
      $fatal(1, "timeout");
   end

endmodule : tb_csi_rx_top

`default_nettype wire

/* sim.f */
+incdir+testbench
hw/csi_rx_pkg.sv
hw/csi_byte_if.sv
hw/csi_word_if.sv
hw/csi_rx_align_byte.sv
hw/csi_rx_align_word.sv
hw/csi_rx_packet_handler.sv
hw/csi_rx_top.sv
testbench/tb_csi_rx_top.sv

/* Bender.yml */
package:
  name: csi_rx

sources:
  - files:
      - hw/csi_rx_pkg.sv
      - hw/csi_byte_if.sv
      - hw/csi_word_if.sv
      - hw/csi_rx_align_byte.sv
      - hw/csi_rx_align_word.sv
      - hw/csi_rx_packet_handler.sv
      - hw/csi_rx_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_csi_rx_top.sv
